// File: verilog.f
+incdir+include
source/bch_pkg.sv
source/bch_axil_regs.sv
source/bch_bit_feeder.sv
source/bch_syndrome_cell.sv
source/bch_syndrome_classify.sv
source/bch_syndrome_top.sv
verif/bch_syndrome_chk.sv
verif/bch_syndrome_tb.sv

// File: verif/bch_syndrome_tb.sv
`include "bch_config.svh"

module bch_syndrome_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import bch_pkg::*;

	localparam int NUM_WORDS = 82;
	localparam int TIMEOUT_CYCLES = NUM_WORDS * 40 + 2000;
	localparam logic [14:0] GEN_WORD = 15'h01d1;   // g(x) = x^8+x^7+x^6+x^4+1
	localparam logic [14:0] PROTO_WORD = 15'h5a3c;

	logic        clk;
	logic        reset;
	logic [7:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	axi_resp_t   bresp;
	logic        bvalid;
	logic        bready;
	logic [7:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	axi_resp_t   rresp;
	logic        rvalid;
	logic        rready;
	int          cycles = 0;

	bch_syndrome_top u_bch_syndrome_top (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$fatal(1, "Timeout");
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("FAILED at %0t: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "Value check failed");
		end
	endtask

	// --------------------------------------------------
	// Reference model
	function automatic gf_elem_t gf_mul_ref(gf_elem_t a, gf_elem_t b);
		logic [6:0] p;
		p = '0;
		for (int i = 0; i < 4; i++)
			if (b[i])
				p = p ^ (7'(a) << i);
		for (int k = 6; k >= 4; k--)   // Fold x^6..x^4 back with x^4+x+1
			if (p[k])
				p = p ^ (7'({1'b1, `BCH_POLY}) << (k - 4));
		return p[3:0];
	endfunction

	function automatic gf_elem_t alpha_pow(int e);
		gf_elem_t x;
		x = 4'd1;
		repeat (e % 15)
			x = gf_mul_ref(x, 4'd2);
		return x;
	endfunction

	// S_j lands in bits 4(j-1)+:4
	function automatic logic [15:0] ref_syndromes(logic [14:0] w);
		logic [15:0] s;
		s = '0;
		for (int j = 1; j <= 4; j++)
			for (int i = 0; i < 15; i++)
				if (w[i])
					s[4*(j-1) +: 4] = s[4*(j-1) +: 4] ^ alpha_pow(i * j);
		return s;
	endfunction

	function automatic err_class_t ref_class(logic [15:0] s);
		gf_elem_t s1;
		s1 = s[3:0];
		if (s == '0)
			return CLEAN;
		if (s1 != '0 && gf_mul_ref(gf_mul_ref(s1, s1), s1) == s[11:8])
			return SINGLE;
		return MULTI;
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// --------------------------------------------------
	// AXI4-Lite master tasks start and end on a rising edge
	task automatic write_request(input logic [7:0] addr, input logic [31:0] data);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(posedge clk);
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
	endtask

	// bready stays low for hold cycles after bvalid
	task automatic write_response(input int hold, output axi_resp_t resp);
		do @(posedge clk);
		while (!bvalid);
		resp = bresp;
		repeat (hold) begin
			@(posedge clk);
			check("bvalid", 1, bvalid);
			check("bresp", resp, bresp);
			check("awready", 0, awready);   // Next write must wait
			check("wready", 0, wready);
		end
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic read_request(input logic [7:0] addr);
		araddr <= addr;
		arvalid <= 1'b1;
		do @(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
	endtask

	task automatic read_response(input int hold, output logic [31:0] data,
			output axi_resp_t resp);
		do @(posedge clk);
		while (!rvalid);
		data = rdata;
		resp = rresp;
		repeat (hold) begin
			@(posedge clk);
			check("rvalid", 1, rvalid);
			check("rdata", data, rdata);
			check("rresp", resp, rresp);
			check("arready", 0, arready);
		end
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			output axi_resp_t resp);
		write_request(addr, data);
		write_response(0, resp);
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
			output axi_resp_t resp);
		read_request(addr);
		read_response(0, data, resp);
	endtask

	task automatic wait_idle(output logic [31:0] status);
		axi_resp_t r;
		do begin
			axi_read(`BCH_ADDR_STATUS, status, r);
			check("rresp", OKAY, r);
		end while (status[0]);
	endtask

	// Result of the last accepted word against the model
	task automatic check_result(input logic [14:0] w);
		axi_resp_t   r;
		logic [31:0] d;
		logic [15:0] s;
		s = ref_syndromes(w);
		wait_idle(d);
		check("status", {29'd0, ref_class(s), 1'b0}, d);
		axi_read(`BCH_ADDR_SYND, d, r);
		check("rresp", OKAY, r);
		check("syndromes", 32'(s), d);
	endtask

	task automatic run_word(input logic [14:0] w);
		axi_resp_t r;
		axi_write(`BCH_ADDR_DATA, 32'(w), r);
		check("bresp", OKAY, r);
		check_result(w);
	endtask

	// --------------------------------------------------
	// Tests
	task automatic test_reset_state();
		axi_resp_t   r;
		logic [31:0] d;
		axi_read(`BCH_ADDR_STATUS, d, r);
		check("rresp", OKAY, r);
		check("status", 0, d);
		axi_read(`BCH_ADDR_SYND, d, r);
		check("rresp", OKAY, r);
		check("syndromes", 0, d);
		axi_read(`BCH_ADDR_DATA, d, r);
		check("rresp", OKAY, r);
		check("rdata", 0, d);
	endtask

	task automatic test_codewords();
		axi_resp_t   r;
		logic [31:0] d;
		logic [14:0] w;
		run_word(15'd0);
		run_word(GEN_WORD);
		axi_read(`BCH_ADDR_STATUS, d, r);
		check("rresp", OKAY, r);
		check("status", 0, d);   // Codeword, idle and CLEAN
		axi_read(`BCH_ADDR_SYND, d, r);
		check("rresp", OKAY, r);
		check("syndromes", 0, d);
		for (int i = 0; i < 15; i++) begin
			w = GEN_WORD ^ (15'd1 << i);
			run_word(w);
			axi_read(`BCH_ADDR_STATUS, d, r);
			check("rresp", OKAY, r);
			check("err_class", SINGLE, d[2:1]);
		end
	endtask

	task automatic test_random_words();
		logic [31:0] rnd;
		rnd = 32'had1d_d3a9;
		repeat (64) begin
			rnd = lcg_next(rnd);
			run_word(rnd[30:16]);
		end
	endtask

	task automatic test_protocol_errors();
		axi_resp_t   r;
		logic [31:0] d;
		axi_write(`BCH_ADDR_DATA, 32'(PROTO_WORD), r);
		check("bresp", OKAY, r);
		axi_write(`BCH_ADDR_DATA, 32'(GEN_WORD), r);   // Lands while busy
		check("bresp", SLVERR, r);
		check_result(PROTO_WORD);
		axi_write(8'h1c, 32'hffff_ffff, r);
		check("bresp", DECERR, r);
		axi_read(8'h1c, d, r);
		check("rresp", DECERR, r);
		check("rdata", 0, d);
		axi_write(`BCH_ADDR_SYND, 32'hffff_ffff, r);
		check("bresp", SLVERR, r);
	endtask

	task automatic test_backpressure();
		axi_resp_t   r;
		logic [31:0] d;
		write_request(`BCH_ADDR_SYND, 32'd0);
		awaddr <= 8'h1c;   // Second write queued behind the stalled response
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		write_response(6, r);
		check("bresp", SLVERR, r);
		write_request(8'h1c, 32'd0);
		write_response(0, r);
		check("bresp", DECERR, r);
		read_request(`BCH_ADDR_STATUS);
		araddr <= `BCH_ADDR_SYND;
		arvalid <= 1'b1;
		read_response(6, d, r);
		check("rresp", OKAY, r);
		check("status", {29'd0, ref_class(ref_syndromes(PROTO_WORD)), 1'b0}, d);
		read_request(`BCH_ADDR_SYND);
		read_response(0, d, r);
		check("rresp", OKAY, r);
		check("syndromes", 32'(ref_syndromes(PROTO_WORD)), d);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		test_reset_state();
		test_codewords();
		test_random_words();
		test_protocol_errors();
		test_backpressure();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: verif/bch_syndrome_chk.sv
module bch_syndrome_chk (
	input logic        clk,
	input logic        reset,
	input logic        bvalid,
	input logic        bready,
	input logic [1:0]  bresp,
	input logic        rvalid,
	input logic        rready,
	input logic [31:0] rdata,
	input logic        busy,
	input logic        start
);
	timeunit 1ns;
	timeprecision 1ps;

	// --------------------------------------------------
	// Response channels hold until taken
	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");
	a_bresp_stable: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> $stable(bresp))
		else $error("bresp changed while the write response was pending");
	a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else $error("rvalid dropped before rready");
	a_rdata_stable: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> $stable(rdata))
		else $error("rdata changed while the read response was pending");

	// --------------------------------------------------
	// Engine timing
	a_busy_len: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> busy [*17] ##1 !busy)
		else $error("busy did not last exactly 17 cycles");
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy)
		else $error("start pulsed while the engine was busy");

endmodule

bind bch_syndrome_top bch_syndrome_chk u_chk (.*);

// File: source/bch_syndrome_top.sv
`include "bch_config.svh"

module bch_syndrome_top (
	input  logic               clk,
	input  logic               reset,
	input  logic [7:0]         awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  logic [31:0]        wdata,
	input  logic [3:0]         wstrb,
	input  logic               wvalid,
	output logic               wready,
	output bch_pkg::axi_resp_t bresp,
	output logic               bvalid,
	input  logic               bready,
	input  logic [7:0]         araddr,
	input  logic               arvalid,
	output logic               arready,
	output logic [31:0]        rdata,
	output bch_pkg::axi_resp_t rresp,
	output logic               rvalid,
	input  logic               rready
);
	import bch_pkg::*;

	logic                        start;
	logic [`BCH_N-1:0]           word;
	logic                        busy;
	logic                        clear;
	logic                        bit_valid;
	logic                        bit_in;
	logic                        last;
	gf_elem_t [2*`BCH_T-1:0]     cell_synd;
	gf_elem_t [2*`BCH_T-1:0]     syndromes;
	err_class_t                  err_class;

	bch_axil_regs u_regs (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.busy(busy), .syndromes(syndromes), .err_class(err_class),
		.start(start), .word(word)
	);

	bch_bit_feeder u_feeder (
		.clk(clk), .reset(reset),
		.start(start), .word(word),
		.busy(busy), .clear(clear), .bit_valid(bit_valid),
		.bit_in(bit_in), .last(last)
	);

	// Cell j computes S_(j+1)
	for (genvar j = 0; j < 2 * `BCH_T; j++) begin : g_cell
		bch_syndrome_cell #(.power(j + 1)) u_cell (
			.clk(clk), .reset(reset),
			.clear(clear), .bit_valid(bit_valid), .bit_in(bit_in),
			.syndrome(cell_synd[j])
		);
	end

	bch_syndrome_classify u_classify (
		.clk(clk), .reset(reset), .last(last),
		.syndrome_in(cell_synd),
		.syndromes(syndromes), .err_class(err_class)
	);

endmodule

// File: source/bch_syndrome_classify.sv
`include "bch_config.svh"

module bch_syndrome_classify (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             last,
	input  bch_pkg::gf_elem_t [2*`BCH_T-1:0] syndrome_in,
	output bch_pkg::gf_elem_t [2*`BCH_T-1:0] syndromes,
	output bch_pkg::err_class_t              err_class
);
	import bch_pkg::*;

	// Shift-and-add GF(2^M) product
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc = acc ^ sh;
			sh = {sh[`BCH_M-2:0], 1'b0} ^ (sh[`BCH_M-1] ? `BCH_POLY : '0);
		end
		return acc;
	endfunction

	logic       capture;   // Cell outputs final one cycle after last
	gf_elem_t   s1_sq;
	gf_elem_t   s1_cube;
	err_class_t next_class;

	assign s1_sq = gf_mul(syndrome_in[0], syndrome_in[0]);
	assign s1_cube = gf_mul(s1_sq, syndrome_in[0]);

	// Single error when S3 = S1^3, valid for T=2 only
	always_comb begin
		if (syndrome_in == '0)
			next_class = CLEAN;
		else if (syndrome_in[0] != '0 && s1_cube == syndrome_in[2])
			next_class = SINGLE;
		else
			next_class = MULTI;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			capture <= 1'b0;
			syndromes <= '0;
			err_class <= CLEAN;
		end else begin
			capture <= last;
			if (capture) begin
				syndromes <= syndrome_in;
				err_class <= next_class;
			end
		end
	end

endmodule

// File: source/bch_syndrome_cell.sv
`include "bch_config.svh"

module bch_syndrome_cell #(
	parameter int power = 1
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              clear,
	input  logic              bit_valid,
	input  logic              bit_in,
	output bch_pkg::gf_elem_t syndrome
);
	import bch_pkg::*;

	// One LFSR step, x times alpha reduced by the field polynomial
	function automatic gf_elem_t mul_alpha(gf_elem_t x);
		return {x[`BCH_M-2:0], 1'b0} ^ (x[`BCH_M-1] ? `BCH_POLY : '0);
	endfunction

	gf_elem_t stage [power+1];

	assign stage[0] = syndrome;

	// Chain of power steps gives the constant multiply by alpha^power
	for (genvar k = 0; k < power; k++) begin : g_step
		assign stage[k+1] = mul_alpha(stage[k]);
	end

	// Horner step, S = S * alpha^j + r_i
	always_ff @(posedge clk) begin
		if (reset || clear)
			syndrome <= '0;
		else if (bit_valid)
			syndrome <= stage[power] ^ gf_elem_t'(bit_in);
	end

endmodule

// File: source/bch_bit_feeder.sv
`include "bch_config.svh"

module bch_bit_feeder (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  logic [`BCH_N-1:0] word,
	output logic              busy,
	output logic              clear,
	output logic              bit_valid,
	output logic              bit_in,
	output logic              last
);
	import bch_pkg::*;

	localparam int CNT_W = $clog2(`BCH_N + 1);

	feed_state_t       state;
	logic [`BCH_N-1:0] shreg;
	logic [CNT_W-1:0]  cnt;   // 0 is the clear cycle, 1..N carry bits

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: if (start) begin
					state <= SHIFT;
					cnt <= '0;
				end
				SHIFT: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_W'(`BCH_N))
						state <= DRAIN;
				end
				DRAIN: state <= IDLE;   // Classifier capture cycle
				default: state <= IDLE;
			endcase
		end
	end

	// Highest degree leaves first
	always_ff @(posedge clk) begin
		if (state == IDLE && start)
			shreg <= word;
		else if (bit_valid)
			shreg <= {shreg[`BCH_N-2:0], 1'b0};
	end

	assign busy = (state != IDLE);
	assign clear = (state == SHIFT) && (cnt == '0);
	assign bit_valid = (state == SHIFT) && (cnt != '0);
	assign bit_in = shreg[`BCH_N-1];
	assign last = (state == SHIFT) && (cnt == CNT_W'(`BCH_N));

endmodule

// File: source/bch_axil_regs.sv
`include "bch_config.svh"

module bch_axil_regs (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic [7:0]                           awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [31:0]                          wdata,
	input  logic [3:0]                           wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output bch_pkg::axi_resp_t                   bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [7:0]                           araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [31:0]                          rdata,
	output bch_pkg::axi_resp_t                   rresp,
	output logic                                 rvalid,
	input  logic                                 rready,
	input  logic                                 busy,
	input  bch_pkg::gf_elem_t [2*`BCH_T-1:0]     syndromes,
	input  bch_pkg::err_class_t                  err_class,
	output logic                                 start,
	output logic [`BCH_N-1:0]                    word
);
	import bch_pkg::*;

	logic        wr_go;
	logic        rd_go;
	logic        wr_data_ok;   // Accepted DATA write, engine idle
	axi_resp_t   wr_resp;
	axi_resp_t   rd_resp;
	logic [31:0] rd_data;

	assign wr_go = awready && awvalid && wvalid;
	assign rd_go = arready && arvalid;

	// --------------------------------------------------
	// Write channel

	always_comb begin
		wr_resp = DECERR;
		wr_data_ok = 1'b0;
		case (awaddr)
			`BCH_ADDR_DATA: begin
				wr_resp = busy ? SLVERR : OKAY;
				wr_data_ok = !busy;
			end
			`BCH_ADDR_STATUS,
			`BCH_ADDR_SYND: wr_resp = SLVERR;   // Read-only
			default: wr_resp = DECERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			start <= 1'b0;
		end else begin
			// Both ready lines pulse together, never with a response pending
			awready <= awvalid && wvalid && !bvalid && !awready;
			wready <= awvalid && wvalid && !bvalid && !awready;
			start <= wr_go && wr_data_ok;
			if (wr_go)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go) begin
			bresp <= wr_resp;
			if (wr_data_ok && wstrb[0])
				word[7:0] <= wdata[7:0];
			if (wr_data_ok && wstrb[1])
				word[`BCH_N-1:8] <= wdata[`BCH_N-1:8];
		end
	end

	// --------------------------------------------------
	// Read channel

	always_comb begin
		rd_resp = OKAY;
		rd_data = '0;
		case (araddr)
			`BCH_ADDR_DATA: rd_data = '0;   // Write-only
			`BCH_ADDR_STATUS: rd_data = {29'd0, err_class, busy};
			`BCH_ADDR_SYND: rd_data = 32'(syndromes);
			default: rd_resp = DECERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !rvalid && !arready;
			if (rd_go)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

endmodule

// File: source/bch_pkg.sv
`include "bch_config.svh"

package bch_pkg;

	// One element of GF(2^M)
	typedef logic [`BCH_M-1:0] gf_elem_t;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		SHIFT = 2'd1,
		DRAIN = 2'd2
	} feed_state_t;

	typedef enum logic [1:0] {
		CLEAN  = 2'd0,
		SINGLE = 2'd1,
		MULTI  = 2'd2
	} err_class_t;

	// AXI response codes, EXOKAY not used
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

endpackage

// File: include/bch_config.svh
`ifndef BCH_CONFIG_SVH
`define BCH_CONFIG_SVH

// Field and code size
`define BCH_M 4
`define BCH_N 15
`define BCH_T 2

// x^4 + x + 1 with the x^4 term dropped
`define BCH_POLY 4'b0011

// --------------------------------------------------
// Register map, byte addresses
`define BCH_ADDR_DATA   8'h00
`define BCH_ADDR_STATUS 8'h04
`define BCH_ADDR_SYND   8'h08

`endif
